// ==== src/board_pkg.sv ====
// ==============================
// Shared board control definitions
//   Host bus types and address map fields
//   Region decode enum
//   Identification constants
// ==============================

package board_pkg;

    // ==============================
    // Bus and register types
    // ==============================
    typedef logic [15:0] bus_addr_t;            // Host byte address
    typedef logic [31:0] bus_data_t;            // Register data word
    typedef logic [1:0]  reg_ofs_t;             // Word offset in a region
    typedef logic [15:0] tick_div_t;            // Tick divider reload
    typedef logic [15:0] gpio_word_t;           // GPIO vector

    // ==============================
    // Address map
    // ==============================
    localparam int REGION_MSB = 15;             // Region select field
    localparam int REGION_LSB = 12;
    localparam int OFS_MSB    = 3;              // Word offset field
    localparam int OFS_LSB    = 2;

    // Region codes from address bits 15:12, others unmapped
    typedef enum logic [3:0] {
        REGION_ID   = 4'd0,                     // Identification and scratch
        REGION_TICK = 4'd1,                     // Tick generator
        REGION_GPIO = 4'd2                      // GPIO block
    } region_t;

    // ==============================
    // Identification words
    // ==============================
    localparam bus_data_t FW_VERSION = 32'h0000_0001;   // Firmware version
    localparam bus_data_t FPGA_ID    = 32'h0000_0100;   // FPGA identifier
    localparam bus_data_t BUILD_DATE = 32'h2025_0822;   // Build date, YYYY_MMDD

    localparam int LED_BIT = 15;                // GPIO out bit for LED after wake-up

endpackage

// ==== src/reg_bus_if.sv ====
// ==============================
// Decoded register access bus
//   One instance per register region
//   ctrl side for decoder, regs side for block
// ==============================

`timescale 1ns/1ps

interface reg_bus_if import board_pkg::*; ();

    logic       stb;                            // Access strobe for this region
    logic       we;                             // Write enable
    reg_ofs_t   ofs;                            // Word offset
    bus_data_t  dat_w;                          // Write data
    bus_data_t  dat_r;                          // Read data, valid with ack
    logic       ack;                            // One-cycle acknowledge

    // Decoder side
    modport ctrl (
        output stb,
        output we,
        output ofs,
        output dat_w,
        input  dat_r,
        input  ack
    );

    // Register block side
    modport regs (
        input  stb,
        input  we,
        input  ofs,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

// ==== src/wb_host_decoder.sv ====
// ==============================
// Wishbone classic host decoder
//   Region decode and strobe routing
//   Read data and ack return mux
//   Local ack for unmapped regions
// ==============================

`timescale 1ns/1ps

module wb_host_decoder import board_pkg::*; (
    input  logic        opb_clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  bus_addr_t   wb_adr,
    input  bus_data_t   wb_dat_w,
    output bus_data_t   wb_dat_r,
    output logic        wb_ack,
    reg_bus_if.ctrl     id_bus,
    reg_bus_if.ctrl     tick_bus,
    reg_bus_if.ctrl     gpio_bus
);

    region_t    region;                         // Decoded region
    reg_ofs_t   ofs;                            // Word offset from address
    logic       acc;                            // Valid host cycle
    logic       unm_sel;                        // Access to unmapped region
    logic       unm_ack;                        // Local ack for unmapped

    assign region = region_t'(wb_adr[REGION_MSB:REGION_LSB]);
    assign ofs    = wb_adr[OFS_MSB:OFS_LSB];
    assign acc    = wb_cyc && wb_stb;

    // ==============================
    // Request routing
    // ==============================
    assign id_bus.stb   = acc && (region == REGION_ID);
    assign tick_bus.stb = acc && (region == REGION_TICK);
    assign gpio_bus.stb = acc && (region == REGION_GPIO);

    assign id_bus.we     = wb_we;               // Shared qualifiers, only stb selects
    assign id_bus.ofs    = ofs;
    assign id_bus.dat_w  = wb_dat_w;
    assign tick_bus.we    = wb_we;
    assign tick_bus.ofs   = ofs;
    assign tick_bus.dat_w = wb_dat_w;
    assign gpio_bus.we    = wb_we;
    assign gpio_bus.ofs   = ofs;
    assign gpio_bus.dat_w = wb_dat_w;

    assign unm_sel = acc && !(region inside {REGION_ID, REGION_TICK, REGION_GPIO});

    // Same one-shot timing as the register blocks, write data dropped
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            unm_ack <= 1'b0;
        end else begin
            unm_ack <= unm_sel && !unm_ack;     // High for one cycle
        end
    end

    // ==============================
    // Response mux
    // ==============================
    always_comb begin
        case (region)
            REGION_ID: begin
                wb_dat_r = id_bus.dat_r;
                wb_ack   = id_bus.ack;
            end
            REGION_TICK: begin
                wb_dat_r = tick_bus.dat_r;
                wb_ack   = tick_bus.ack;
            end
            REGION_GPIO: begin
                wb_dat_r = gpio_bus.dat_r;
                wb_ack   = gpio_bus.ack;
            end
            default: begin
                wb_dat_r = '0;                  // Unmapped reads as zero
                wb_ack   = unm_ack;
            end
        endcase
    end

endmodule

// ==== src/id_scratch_regs.sv ====
// ==============================
// Identification and scratch registers
//   Offsets 0..2 read-only ID words
//   Offset 3 read/write scratch
// ==============================

`timescale 1ns/1ps

module id_scratch_regs import board_pkg::*; (
    input  logic        opb_clk,
    input  logic        rst_n,
    reg_bus_if.regs     bus
);

    bus_data_t  scratch;                        // Scratch register
    logic       wr_en;                          // Write on ack edge

    assign wr_en = bus.stb && bus.we && !bus.ack;

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
            scratch <= '0;
        end else begin
            bus.ack <= bus.stb && !bus.ack;     // One-cycle ack
            if (wr_en && (bus.ofs == 2'd3)) begin
                scratch <= bus.dat_w;           // Only writable word
            end
        end
    end

    // Read mux, held stable by the host during ack
    always_comb begin
        case (bus.ofs)
            2'd0:    bus.dat_r = FW_VERSION;
            2'd1:    bus.dat_r = FPGA_ID;
            2'd2:    bus.dat_r = BUILD_DATE;
            default: bus.dat_r = scratch;
        endcase
    end

endmodule

// ==== src/tick_gen.sv ====
// ==============================
// Programmable tick generator
//   Divider register and down-counter
//   Reference pulse, heartbeat toggle
//   32-bit tick counter
// ==============================

`timescale 1ns/1ps

module tick_gen import board_pkg::*; #(
    parameter tick_div_t TICK_DIV_RESET = 16'd49999,   // Divider after reset
    parameter int        HB_TICKS       = 1000         // Ticks per heartbeat flip
) (
    input  logic        opb_clk,
    input  logic        rst_n,
    reg_bus_if.regs     bus,
    output logic        ref_pulse,
    output logic        hb_toggle
);

    localparam int HB_W = $clog2(HB_TICKS + 1);         // Heartbeat count width

    tick_div_t          div_reg;                // Divider reload value
    tick_div_t          cnt;                    // Down-counter
    logic               tick;                   // One cycle every div+1
    bus_data_t          tick_cnt;               // Ticks since clear
    logic [HB_W-1:0]    hb_cnt;                 // Ticks in current heartbeat phase
    logic               wr_en;

    assign wr_en = bus.stb && bus.we && !bus.ack;
    assign tick  = (cnt == '0);

    // ==============================
    // Divider and tick counting
    // ==============================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack   <= 1'b0;
            div_reg   <= TICK_DIV_RESET;
            cnt       <= TICK_DIV_RESET;
            tick_cnt  <= '0;
            hb_cnt    <= '0;
            hb_toggle <= 1'b0;
            ref_pulse <= 1'b0;
        end else begin
            bus.ack   <= bus.stb && !bus.ack;
            ref_pulse <= tick;                  // Tick delayed one cycle

            if (wr_en && (bus.ofs == 2'd0)) begin
                div_reg <= bus.dat_w[15:0];
                cnt     <= bus.dat_w[15:0];     // New period starts now
            end else if (tick) begin
                cnt <= div_reg;                 // Reload
            end else begin
                cnt <= cnt - 1'b1;
            end

            if (wr_en && (bus.ofs == 2'd1)) begin
                tick_cnt <= '0;                 // Write clears, data ignored
            end else if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            if (tick) begin
                if (hb_cnt == HB_W'(HB_TICKS - 1)) begin
                    hb_cnt    <= '0;
                    hb_toggle <= ~hb_toggle;    // Slow heartbeat flip
                end else begin
                    hb_cnt <= hb_cnt + 1'b1;
                end
            end
        end
    end

    // Register read mux
    always_comb begin
        case (bus.ofs)
            2'd0:    bus.dat_r = {16'h0000, div_reg};
            2'd1:    bus.dat_r = tick_cnt;
            default: bus.dat_r = '0;            // Unused offsets
        endcase
    end

endmodule

// ==== src/gpio_regs.sv ====
// ==============================
// GPIO register block
//   Two-flop input synchroniser
//   Input and output registers
// ==============================

`timescale 1ns/1ps

module gpio_regs import board_pkg::*; (
    input  logic        opb_clk,
    input  logic        rst_n,
    reg_bus_if.regs     bus,
    input  gpio_word_t  gpio_in,
    output gpio_word_t  gpio_out
);

    gpio_word_t in_meta;                        // First sync stage
    gpio_word_t in_reg;                         // Synchronised input register
    logic       wr_en;

    assign wr_en = bus.stb && bus.we && !bus.ack;

    // ==============================
    // Input synchroniser
    // ==============================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_reg  <= '0;
        end else begin
            in_meta <= gpio_in;                 // May go metastable
            in_reg  <= in_meta;                 // Stable after two edges
        end
    end

    // ==============================
    // Bus side and output register
    // ==============================
    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack  <= 1'b0;
            gpio_out <= '0;                     // Outputs off at reset
        end else begin
            bus.ack <= bus.stb && !bus.ack;
            if (wr_en && (bus.ofs == 2'd1)) begin
                gpio_out <= bus.dat_w[15:0];
            end
        end
    end

    always_comb begin
        case (bus.ofs)
            2'd0:    bus.dat_r = {16'h0000, in_reg};
            2'd1:    bus.dat_r = {16'h0000, gpio_out};
            default: bus.dat_r = '0;
        endcase
    end

endmodule

// ==== src/heartbeat_led.sv ====
// ==============================
// Heartbeat LED control
//   Sticky wake-up flag
//   Registered LED source select
// ==============================

`timescale 1ns/1ps

module heartbeat_led (
    input  logic    opb_clk,
    input  logic    rst_n,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    hb_toggle,
    input  logic    led_ctrl,
    output logic    heartbeat_led_n
);

    logic   wake_up;                            // Set by first host access

    always_ff @(posedge opb_clk or negedge rst_n) begin
        if (!rst_n) begin
            wake_up         <= 1'b0;
            heartbeat_led_n <= 1'b1;            // LED dark
        end else begin
            if (wb_cyc && wb_stb) begin
                wake_up <= 1'b1;                // Never cleared until reset
            end
            // Free-running blink until software takes over
            if (wake_up) begin
                heartbeat_led_n <= ~led_ctrl;
            end else begin
                heartbeat_led_n <= ~hb_toggle;
            end
        end
    end

endmodule

// ==== src/board_ctrl_top.sv ====
// ==============================
// Board control core top level
//   Wishbone host port
//   ID, tick and GPIO register blocks
//   Heartbeat LED
// ==============================

`timescale 1ns/1ps

module board_ctrl_top import board_pkg::*; #(
    parameter tick_div_t TICK_DIV_RESET = 16'd49999,   // 2 kHz at 100 MHz
    parameter int        HB_TICKS       = 1000         // About 1 Hz toggle
) (
    input  logic        opb_clk,
    input  logic        rst_n,
    // Host bus
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  bus_addr_t   wb_adr,
    input  bus_data_t   wb_dat_w,
    output bus_data_t   wb_dat_r,
    output logic        wb_ack,
    // Board pins
    input  gpio_word_t  gpio_in,
    output gpio_word_t  gpio_out,
    output logic        ref_pulse,              // Reference pulse out
    output logic        heartbeat_led_n         // Active-low LED
);

    logic   hb_toggle;                          // Slow toggle from tick_gen

    reg_bus_if id_bus ();
    reg_bus_if tick_bus ();
    reg_bus_if gpio_bus ();

    // ==============================
    // Host decoder
    // ==============================
    wb_host_decoder u_decoder (
        .opb_clk  (opb_clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .id_bus   (id_bus.ctrl),
        .tick_bus (tick_bus.ctrl),
        .gpio_bus (gpio_bus.ctrl)
    );

    // ==============================
    // Register blocks
    // ==============================
    id_scratch_regs u_id_regs (
        .opb_clk (opb_clk),
        .rst_n   (rst_n),
        .bus     (id_bus.regs)
    );

    tick_gen #(
        .TICK_DIV_RESET (TICK_DIV_RESET),
        .HB_TICKS       (HB_TICKS)
    ) u_tick_gen (
        .opb_clk   (opb_clk),
        .rst_n     (rst_n),
        .bus       (tick_bus.regs),
        .ref_pulse (ref_pulse),
        .hb_toggle (hb_toggle)
    );

    gpio_regs u_gpio (
        .opb_clk  (opb_clk),
        .rst_n    (rst_n),
        .bus      (gpio_bus.regs),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    heartbeat_led u_hb_led (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .hb_toggle       (hb_toggle),
        .led_ctrl        (gpio_out[LED_BIT]),   // Software LED bit
        .heartbeat_led_n (heartbeat_led_n)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
// ==============================
// Testbench clock and reset
//   Free-running clock
//   Active-low reset for N cycles
// ==============================

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 40.0,         // 25 MHz
    parameter int  RESET_CYCLES = 3
) (
    output logic opb_clk,
    output logic rst_n
);

    initial begin
        opb_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) opb_clk = ~opb_clk;
    end

    initial begin
        rst_n = 1'b0;                           // Held from time zero
        repeat (RESET_CYCLES) @(posedge opb_clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== verif/board_ctrl_checker.sv ====
// ==============================
// Bound protocol checker
//   Wishbone ack shape
//   Reference pulse width
// ==============================

`timescale 1ns/1ps

module board_ctrl_checker (
    input logic opb_clk,
    input logic rst_n,
    input logic wb_stb,
    input logic wb_ack,
    input logic ref_pulse
);

    int fail_cnt = 0;                           // Failed assertion count

    // Ack is a single-cycle strobe
    ack_one_cycle: assert property (@(posedge opb_clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            fail_cnt++;
            $error("wb_ack high for two consecutive cycles");
        end

    // No ack outside a request
    ack_with_stb: assert property (@(posedge opb_clk) disable iff (!rst_n)
        wb_ack |-> wb_stb)
        else begin
            fail_cnt++;
            $error("wb_ack high while wb_stb is low");
        end

    pulse_one_cycle: assert property (@(posedge opb_clk) disable iff (!rst_n)
        ref_pulse |=> !ref_pulse)
        else begin
            fail_cnt++;
            $error("ref_pulse longer than one cycle");
        end

endmodule

bind board_ctrl_top board_ctrl_checker u_checker (
    .opb_clk   (opb_clk),
    .rst_n     (rst_n),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .ref_pulse (ref_pulse)
);

// ==== verif/board_ctrl_tb.sv ====
// ==============================
// Board control core testbench
//   Pattern file driven host accesses
//   Pulse and heartbeat spacing checks
//   Watchdog
// ==============================

`timescale 1ns/1ps

module board_ctrl_tb import board_pkg::*; ();

    logic       opb_clk;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    bus_addr_t  wb_adr;
    bus_data_t  wb_dat_w;
    bus_data_t  wb_dat_r;
    logic       wb_ack;
    gpio_word_t gpio_in;
    gpio_word_t gpio_out;
    logic       ref_pulse;
    logic       heartbeat_led_n;

    string      pat_op[$];                      // One entry per pattern line
    bus_data_t  pat_adr[$];
    bus_data_t  pat_wdat[$];
    bus_data_t  pat_gpio[$];
    bus_data_t  pat_exp[$];
    int         err_cnt = 0;
    int         limit_cycles;                   // Watchdog budget

    tb_clock_gen #(.PERIOD_NS(40.0), .RESET_CYCLES(3)) u_clk (
        .opb_clk (opb_clk),
        .rst_n   (rst_n)
    );

    board_ctrl_top #(.TICK_DIV_RESET(16'd9), .HB_TICKS(4)) uut (
        .opb_clk         (opb_clk),
        .rst_n           (rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack),
        .gpio_in         (gpio_in),
        .gpio_out        (gpio_out),
        .ref_pulse       (ref_pulse),
        .heartbeat_led_n (heartbeat_led_n)
    );

    // ==============================
    // Failure reporting
    // ==============================
    task automatic stop_with_failure();
        err_cnt++;
        $display("Done: errors found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string what, input bus_data_t got,
                                   input bus_data_t exp);
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        stop_with_failure();
    endtask

    // ==============================
    // Pattern file and bus helpers
    // ==============================
    task automatic load_patterns();
        int        fd;
        int        n;
        string     line;
        string     op;
        bus_data_t a;
        bus_data_t w;
        bus_data_t g;
        bus_data_t e;
        fd = $fopen("verif/board_ctrl_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the pattern file verif/board_ctrl_patterns.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %h %h %h %h", op, a, w, g, e);
            if (n == 5 && op.getc(0) != 8'h23) begin   // Skip comments and blanks
                pat_op.push_back(op);
                pat_adr.push_back(a);
                pat_wdat.push_back(w);
                pat_gpio.push_back(g);
                pat_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // Classic cycle, held until ack is sampled
    task automatic bus_access(input logic we, input bus_addr_t adr,
                              input bus_data_t wdat, output bus_data_t rdat);
        int waited;
        waited = 0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        do begin
            @(posedge opb_clk);
            waited++;
        end while (wb_ack !== 1'b1 && waited < 16);
        assert (wb_ack === 1'b1) else begin
            $display("No acknowledge from the DUT for address %h", adr);
            stop_with_failure();
        end
        rdat = wb_dat_r;                        // Valid with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge opb_clk);                     // Idle cycle between accesses
    endtask

    // Cycles between two events: LED edges for H, pulses for P
    task automatic measure_spacing(input string kind, output int cycles);
        logic prev_led;
        logic ev;
        int   seen;
        int   n;
        seen     = 0;
        n        = 0;
        cycles   = 0;
        prev_led = heartbeat_led_n;
        while (seen < 2 && n < 400) begin
            @(posedge opb_clk);
            n++;
            if (seen == 1) cycles++;
            if (kind == "H") ev = (heartbeat_led_n !== prev_led);
            else ev = (ref_pulse === 1'b1);
            if (ev) seen++;
            prev_led = heartbeat_led_n;
        end
        assert (seen == 2) else begin
            $display("Expected events on %s did not occur within 400 cycles", kind);
            stop_with_failure();
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        bus_data_t rdat;
        int        cyc;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        gpio_in  = '0;
        load_patterns();
        limit_cycles = 200 * pat_op.size() + 2000;
        fork
            begin
                repeat (limit_cycles) @(posedge opb_clk);
                $display("Timeout after %0d cycles, the test did not finish", limit_cycles);
                stop_with_failure();
            end
            begin
                wait (uut.u_checker.fail_cnt != 0);
                $display("A bus or pulse protocol assertion failed in the bound checker");
                stop_with_failure();
            end
        join_none
        wait (rst_n === 1'b1);
        @(posedge opb_clk);
        foreach (pat_op[i]) begin
            gpio_in <= pat_gpio[i][15:0];
            repeat (3) @(posedge opb_clk);      // Past the input synchroniser
            case (pat_op[i])
                "W": begin
                    bus_access(1'b1, pat_adr[i][15:0], pat_wdat[i], rdat);
                    // GPIO output register drives the pins
                    if (pat_adr[i][15:12] == 4'd2 && pat_adr[i][3:2] == 2'd1) begin
                        assert (gpio_out === pat_wdat[i][15:0])
                            else report_mismatch("gpio_out", bus_data_t'(gpio_out),
                                                 bus_data_t'(pat_wdat[i][15:0]));
                    end
                end
                "R": begin
                    bus_access(1'b0, pat_adr[i][15:0], '0, rdat);
                    assert (rdat === pat_exp[i])
                        else report_mismatch($sformatf("read %h", pat_adr[i][15:0]),
                                             rdat, pat_exp[i]);
                end
                "H", "P": begin
                    measure_spacing(pat_op[i], cyc);
                    assert (cyc == pat_exp[i])
                        else report_mismatch($sformatf("%s spacing", pat_op[i]),
                                             bus_data_t'(cyc), pat_exp[i]);
                end
                "L": begin
                    assert (heartbeat_led_n === pat_exp[i][0])
                        else report_mismatch("heartbeat_led_n",
                                             bus_data_t'(heartbeat_led_n), pat_exp[i]);
                end
                default: begin
                    $display("Unknown operation %s on pattern line %0d", pat_op[i], i);
                    stop_with_failure();
                end
            endcase
        end
        if (err_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== verif/board_ctrl_patterns.txt ====
# op addr wdata gpio_in expected, all hex
# H LED edge spacing, P ref_pulse spacing, W write, R read, L LED level
H 0000 00000000 0000 00000028
P 0000 00000000 0000 0000000a
R 0000 00000000 0000 00000001
R 0004 00000000 0000 00000100
R 0008 00000000 0000 20250822
W 0000 deadbeef 0000 00000000
W 0008 12345678 0000 00000000
R 0000 00000000 0000 00000001
R 0008 00000000 0000 20250822
R 000c 00000000 0000 00000000
W 000c a5a55a5a 0000 00000000
R 000c 00000000 0000 a5a55a5a
R 1000 00000000 0000 00000009
W 1000 00000005 0000 00000000
R 1000 00000000 0000 00000005
P 0000 00000000 0000 00000006
W 2004 00008001 0000 00000000
R 2004 00000000 0000 00008001
L 0000 00000000 0000 00000000
W 2004 00000003 0000 00000000
L 0000 00000000 0000 00000001
R 2000 00000000 3c5a 00003c5a
W 3000 ffffffff 3c5a 00000000
R 3000 00000000 0000 00000000
R f00c 00000000 0000 00000000

// ==== compile.f ====
src/board_pkg.sv
src/reg_bus_if.sv
src/wb_host_decoder.sv
src/id_scratch_regs.sv
src/tick_gen.sv
src/gpio_regs.sv
src/heartbeat_led.sv
src/board_ctrl_top.sv
verif/tb_clock_gen.sv
verif/board_ctrl_checker.sv
verif/board_ctrl_tb.sv
